//--- include/control_settings.svh
// ======================================================================
// fixed chip addresses, widths and read-source codes of the SRAM control
// block; include wherever a width, an address or a source code is needed
// ======================================================================
`ifndef CONTROL_SETTINGS_SVH
`define CONTROL_SETTINGS_SVH

// data bus and command address width
`define CTL_DATA_W 32
// array row address width (32 rows)
`define CTL_ROW_W 5
// read wait count width of the cfg0[2:0] field
`define CTL_WAIT_W 3

// address map with the region nibble in bits 15:12
`define CTL_REGION_MASK 32'h0000_F000
`define CTL_CFG_REGION 32'h0000_E000
`define CTL_BIST_REGION 32'h0000_F000
// offset of cfg0 within the 12 bit offset field
`define CTL_CFG0_OFFSET 12'h000
// one read wait cycle so a read acks two cycles after its command
`define CTL_CFG0_INIT 32'h0000_0001

// read-source codes where anything above 6 reads as all ones
`define CTL_SRC_W 3
`define CTL_SRC_R0 3'd0
`define CTL_SRC_R1 3'd1
`define CTL_SRC_DUAL_LO 3'd2
`define CTL_SRC_DUAL_HI 3'd3
`define CTL_SRC_CFG0 3'd4
`define CTL_SRC_BIST 3'd5
`define CTL_SRC_ACFG 3'd6

`endif

//--- logic/toysram_adr_pkg.sv
// ======================================================================
// command address word and its region and port decodings
// ======================================================================
`default_nettype none

`include "control_settings.svh"

package toysram_adr_pkg;

  // region view, used by both command spaces
  typedef struct packed {
    logic [15:0] upper;
    // selects bist, array config or plain
    logic [3:0]  region;
    // cfg0 lives at offset 0 of the control space
    logic [11:0] offset;
  } adr_region_s;

  // port view, only meaningful for plain array accesses
  typedef struct packed {
    logic [15:0]            upper;
    // 00 r0, 01 r1, 10 dual low, 11 dual high
    logic [1:0]             rd_type;
    logic [2:0]             spare_hi;
    // second row for dual reads
    logic [`CTL_ROW_W-1:0]  r1_row;
    logic                   spare_lo;
    // row for r0, w0 and single r1 reads
    logic [`CTL_ROW_W-1:0]  r0_row;
  } adr_port_s;

  // one address, read either way
  typedef union packed {
    logic [`CTL_DATA_W-1:0] word;
    adr_region_s            region;
    adr_port_s              port;
  } cmd_adr_u;

endpackage

`default_nettype wire

//--- logic/toysram_data_pkg.sv
// ======================================================================
// array data word, seen whole or as two 16 bit halves
// ======================================================================
`default_nettype none

`include "control_settings.svh"

package toysram_data_pkg;

  // halves used by the dual-port reads
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } array_halves_s;

  // one array row word
  typedef union packed {
    logic [`CTL_DATA_W-1:0] word;
    array_halves_s          halves;
  } array_word_u;

endpackage

`default_nettype wire

//--- logic/cmd_decode.sv
// ======================================================================
// turns each host command into array port strobes, a cfg0 write request
// and a coded read request, all in the command cycle
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "control_settings.svh"

module cmd_decode (
  input  wire                          ctl_cmd_val,
  input  wire                          ra0_cmd_val,
  input  wire                          cmd_we,
  input  wire toysram_adr_pkg::cmd_adr_u cmd_adr,
  input  wire  [3:0]                   cmd_sel,
  input  wire  [`CTL_DATA_W-1:0]       cmd_dat,
  output logic                         ra0_r0_enb,
  output logic                         ra0_r1_enb,
  output logic                         ra0_w0_enb,
  output logic [`CTL_ROW_W-1:0]        ra0_r0_adr,
  output logic [`CTL_ROW_W-1:0]        ra0_r1_adr,
  output logic [`CTL_ROW_W-1:0]        ra0_w0_adr,
  output logic [`CTL_DATA_W-1:0]       ra0_w0_dat,
  output logic [`CTL_DATA_W-1:0]       ra0_bist_ctl,
  output logic [`CTL_DATA_W-1:0]       ra0_cfg_wdat,
  output logic                         ra0_cfg_wr,
  output logic                         cfg0_wr,
  output logic [`CTL_DATA_W-1:0]       cfg0_wdat,
  output logic                         rd_req,
  output logic [`CTL_SRC_W-1:0]        rd_src
);

  import toysram_adr_pkg::*;

  // region nibbles of the two special regions
  localparam logic [3:0] bist_nib = 4'((`CTL_BIST_REGION & `CTL_REGION_MASK) >> 12);
  localparam logic [3:0] cfg_nib = 4'((`CTL_CFG_REGION & `CTL_REGION_MASK) >> 12);

  adr_region_s                 region_view;
  adr_port_s                   port_view;
  logic                        adr_bist;
  logic                        adr_config;
  logic                        special;
  logic                        ctl_rd;
  logic                        ctl_wr;
  logic                        ra_rd;
  logic                        ra_wr;
  logic [`CTL_SRC_W-1:0]       ctl_src;
  logic [`CTL_SRC_W-1:0]       ra_src;

  // both views decoded once
  assign region_view = cmd_adr.region;
  assign port_view   = cmd_adr.port;

  // region decode, same for both spaces
  assign adr_bist   = region_view.region == bist_nib;
  assign adr_config = region_view.region == cfg_nib;
  assign special    = adr_bist | adr_config;

  assign ctl_rd = ctl_cmd_val & ~cmd_we;
  assign ctl_wr = ctl_cmd_val & cmd_we;
  assign ra_rd  = ra0_cmd_val & ~cmd_we;
  assign ra_wr  = ra0_cmd_val & cmd_we;

  // cfg0 write ignores the region, only the offset matters
  assign cfg0_wr   = ctl_wr & (region_view.offset == `CTL_CFG0_OFFSET);
  assign cfg0_wdat = cmd_dat;

  // special array regions pass straight through
  assign ra0_bist_ctl = (ra_wr & adr_bist) ? cmd_dat : '0;
  assign ra0_cfg_wr   = ra_wr & adr_config;
  assign ra0_cfg_wdat = cmd_dat;

  // write port, byte select 0 acts as the port enable
  assign ra0_w0_enb = ra_wr & cmd_sel[0];
  assign ra0_w0_adr = port_view.r0_row;
  assign ra0_w0_dat = cmd_dat;

  // read ports, r0 unless type 01, r1 unless type 00
  assign ra0_r0_enb = ra_rd & ~special & (port_view.rd_type != 2'b01);
  assign ra0_r1_enb = ra_rd & ~special & (port_view.rd_type != 2'b00);
  assign ra0_r0_adr = port_view.r0_row;
  // single r1 read reuses the r0 row field
  assign ra0_r1_adr = (port_view.rd_type == 2'b01) ? port_view.r0_row : port_view.r1_row;

  // control space source
  always_comb begin
    if (adr_bist) begin
      ctl_src = `CTL_SRC_BIST;
    end else if (adr_config) begin
      ctl_src = `CTL_SRC_ACFG;
    end else begin
      ctl_src = `CTL_SRC_CFG0;
    end
  end

  // array source follows rd_type, even in a special region
  always_comb begin
    case (port_view.rd_type)
      2'b00:   ra_src = `CTL_SRC_R0;
      2'b01:   ra_src = `CTL_SRC_R1;
      2'b10:   ra_src = `CTL_SRC_DUAL_LO;
      default: ra_src = `CTL_SRC_DUAL_HI;
    endcase
  end

  // one read request per read command
  assign rd_req = ctl_rd | ra_rd;
  assign rd_src = ra0_cmd_val ? ra_src : ctl_src;

endmodule

`default_nettype wire

//--- logic/read_sequencer.sv
// ======================================================================
// holds cfg0 and times every read, rd_ack comes cfg0[2:0]+1 cycles
// after the command and carries the latched source select
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "control_settings.svh"

module read_sequencer (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    cfg0_wr,
  input  wire  [`CTL_DATA_W-1:0] cfg0_wdat,
  input  wire                    rd_req,
  input  wire  [`CTL_SRC_W-1:0]  rd_src,
  output logic [`CTL_DATA_W-1:0] cfg0,
  output logic                   rd_ack,
  output logic [`CTL_SRC_W-1:0]  rdata_sel
);

  // idle when low, one read in flight when high
  logic                   busy;
  // remaining wait cycles before the ack
  logic [`CTL_WAIT_W-1:0] wait_cnt;
  logic                   rd_start;
  logic                   cnt_zero;

  // cfg0
  //   31:3 reserved, read back as written
  //   2:0  read wait cycles after the command cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg0 <= `CTL_CFG0_INIT;
    end else if (cfg0_wr) begin
      cfg0 <= cfg0_wdat;
    end
  end

  // requests while busy are dropped, no back-pressure
  assign rd_start = rd_req & ~busy;

  assign cnt_zero = wait_cnt == '0;

  // ack in the first busy cycle that finds the count at zero
  assign rd_ack = busy & cnt_zero;

  // state and wait counter
  //   command cycle k loads N, cycle k+1 sees N
  //   count reaches zero at k+N+1, ack there
  //   back to idle at k+N+2
  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      wait_cnt <= '0;
    end else if (rd_start) begin
      busy     <= 1'b1;
      wait_cnt <= cfg0[`CTL_WAIT_W-1:0];
    end else if (rd_ack) begin
      busy <= 1'b0;
    end else if (!cnt_zero) begin
      wait_cnt <= wait_cnt - 1'b1;
    end
  end

  // source select held for the whole read, the return mux needs it
  // only in the ack cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata_sel <= `CTL_SRC_CFG0;
    end else if (rd_start) begin
      rdata_sel <= rd_src;
    end
  end

endmodule

`default_nettype wire

//--- logic/read_return.sv
// ======================================================================
// selects the read word for rd_dat, valid in the rd_ack cycle
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "control_settings.svh"

module read_return (
  input  wire  [`CTL_SRC_W-1:0]             rdata_sel,
  input  wire toysram_data_pkg::array_word_u ra0_r0_dat,
  input  wire toysram_data_pkg::array_word_u ra0_r1_dat,
  input  wire  [`CTL_DATA_W-1:0]            cfg0,
  input  wire  [`CTL_DATA_W-1:0]            ra0_bist_status,
  input  wire  [`CTL_DATA_W-1:0]            ra0_cfg_rdat,
  output logic [`CTL_DATA_W-1:0]            rd_dat
);

  import toysram_data_pkg::*;

  // dual reads, r1 half on top of the r0 half
  array_word_u dual_lo;
  array_word_u dual_hi;

  always_comb begin
    dual_lo.halves.hi = ra0_r1_dat.halves.lo;
    dual_lo.halves.lo = ra0_r0_dat.halves.lo;
    dual_hi.halves.hi = ra0_r1_dat.halves.hi;
    dual_hi.halves.lo = ra0_r0_dat.halves.hi;
  end

  always_comb begin
    case (rdata_sel)
      `CTL_SRC_R0:      rd_dat = ra0_r0_dat.word;
      `CTL_SRC_R1:      rd_dat = ra0_r1_dat.word;
      `CTL_SRC_DUAL_LO: rd_dat = dual_lo.word;
      `CTL_SRC_DUAL_HI: rd_dat = dual_hi.word;
      `CTL_SRC_CFG0:    rd_dat = cfg0;
      `CTL_SRC_BIST:    rd_dat = ra0_bist_status;
      `CTL_SRC_ACFG:    rd_dat = ra0_cfg_rdat;
      // unused code
      default:          rd_dat = '1;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/toysram_control.sv
// ======================================================================
// top of the SRAM test-chip command controller, host ports on one side
// and the array ports on the other
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "control_settings.svh"

module toysram_control (
  input  wire                               clk,
  input  wire                               rst,
  // host commands
  input  wire                               ctl_cmd_val,
  input  wire                               ra0_cmd_val,
  input  wire toysram_adr_pkg::cmd_adr_u    cmd_adr,
  input  wire                               cmd_we,
  input  wire  [3:0]                        cmd_sel,
  input  wire  [`CTL_DATA_W-1:0]            cmd_dat,
  output logic                              rd_ack,
  output logic [`CTL_DATA_W-1:0]            rd_dat,
  // array
  output logic                              ra0_clk,
  output logic                              ra0_rst,
  output logic                              ra0_cfg_wr,
  input  wire  [`CTL_DATA_W-1:0]            ra0_cfg_rdat,
  output logic [`CTL_DATA_W-1:0]            ra0_cfg_wdat,
  output logic [`CTL_DATA_W-1:0]            ra0_bist_ctl,
  input  wire  [`CTL_DATA_W-1:0]            ra0_bist_status,
  output logic                              ra0_r0_enb,
  output logic [`CTL_ROW_W-1:0]             ra0_r0_adr,
  input  wire toysram_data_pkg::array_word_u ra0_r0_dat,
  output logic                              ra0_r1_enb,
  output logic [`CTL_ROW_W-1:0]             ra0_r1_adr,
  input  wire toysram_data_pkg::array_word_u ra0_r1_dat,
  output logic                              ra0_w0_enb,
  output logic [`CTL_ROW_W-1:0]             ra0_w0_adr,
  output logic [`CTL_DATA_W-1:0]            ra0_w0_dat
);

  logic                   cfg0_wr;
  logic [`CTL_DATA_W-1:0] cfg0_wdat;
  logic                   rd_req;
  logic [`CTL_SRC_W-1:0]  rd_src;
  logic [`CTL_DATA_W-1:0] cfg0;
  logic [`CTL_SRC_W-1:0]  rdata_sel;

  // array runs on the controller clock and reset
  assign ra0_clk = clk;
  assign ra0_rst = rst;

  cmd_decode cmd_decode_i (
    .ctl_cmd_val  (ctl_cmd_val),
    .ra0_cmd_val  (ra0_cmd_val),
    .cmd_we       (cmd_we),
    .cmd_adr      (cmd_adr),
    .cmd_sel      (cmd_sel),
    .cmd_dat      (cmd_dat),
    .ra0_r0_enb   (ra0_r0_enb),
    .ra0_r1_enb   (ra0_r1_enb),
    .ra0_w0_enb   (ra0_w0_enb),
    .ra0_r0_adr   (ra0_r0_adr),
    .ra0_r1_adr   (ra0_r1_adr),
    .ra0_w0_adr   (ra0_w0_adr),
    .ra0_w0_dat   (ra0_w0_dat),
    .ra0_bist_ctl (ra0_bist_ctl),
    .ra0_cfg_wdat (ra0_cfg_wdat),
    .ra0_cfg_wr   (ra0_cfg_wr),
    .cfg0_wr      (cfg0_wr),
    .cfg0_wdat    (cfg0_wdat),
    .rd_req       (rd_req),
    .rd_src       (rd_src)
  );

  read_sequencer read_sequencer_i (
    .clk       (clk),
    .rst       (rst),
    .cfg0_wr   (cfg0_wr),
    .cfg0_wdat (cfg0_wdat),
    .rd_req    (rd_req),
    .rd_src    (rd_src),
    .cfg0      (cfg0),
    .rd_ack    (rd_ack),
    .rdata_sel (rdata_sel)
  );

  read_return read_return_i (
    .rdata_sel       (rdata_sel),
    .ra0_r0_dat      (ra0_r0_dat),
    .ra0_r1_dat      (ra0_r1_dat),
    .cfg0            (cfg0),
    .ra0_bist_status (ra0_bist_status),
    .ra0_cfg_rdat    (ra0_cfg_rdat),
    .rd_dat          (rd_dat)
  );

endmodule

`default_nettype wire

//--- test/toysram_control_properties.sv
// ======================================================================
// read timing and enable properties, bound into the controller top level
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "control_settings.svh"

module toysram_control_properties (
  input wire                   clk,
  input wire                   rst,
  input wire                   ctl_cmd_val,
  input wire                   ra0_cmd_val,
  input wire                   rd_req,
  input wire                   rd_ack,
  input wire                   ra0_r0_enb,
  input wire                   ra0_r1_enb,
  input wire                   ra0_w0_enb,
  input wire [`CTL_DATA_W-1:0] cfg0
);

  // count of failed properties, watched by the testbench
  int unsigned            fail_cnt = 0;
  // one read outstanding between acceptance and its ack
  logic                   in_flight;
  logic [`CTL_WAIT_W-1:0] target;
  int unsigned            since;
  logic                   accepted;

  // a request only counts while nothing is outstanding
  assign accepted = rd_req & ~in_flight;

  // since is 0 in the first cycle after the command, so the ack is due at N
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= 1'b0;
      target    <= '0;
      since     <= 0;
    end else if (accepted) begin
      in_flight <= 1'b1;
      target    <= cfg0[`CTL_WAIT_W-1:0];
      since     <= 0;
    end else if (rd_ack) begin
      in_flight <= 1'b0;
    end else begin
      since <= since + 1;
    end
  end

  single_ack: assert property (@(posedge clk) disable iff (rst) rd_ack |=> !rd_ack)
    else begin
      fail_cnt++;
      $error("rd_ack high in two consecutive cycles");
    end

  ack_latency: assert property (@(posedge clk) disable iff (rst)
      rd_ack == (in_flight && since == target))
    else begin
      fail_cnt++;
      $error("rd_ack not exactly cfg0[2:0]+1 cycles after the accepted read");
    end

  quiet_enables: assert property (@(posedge clk) disable iff (rst)
      !ctl_cmd_val && !ra0_cmd_val |-> !(ra0_r0_enb || ra0_r1_enb || ra0_w0_enb))
    else begin
      fail_cnt++;
      $error("array enable raised without a command strobe");
    end

endmodule

bind toysram_control toysram_control_properties toysram_control_properties_i (
  .clk         (clk),
  .rst         (rst),
  .ctl_cmd_val (ctl_cmd_val),
  .ra0_cmd_val (ra0_cmd_val),
  .rd_req      (rd_req),
  .rd_ack      (rd_ack),
  .ra0_r0_enb  (ra0_r0_enb),
  .ra0_r1_enb  (ra0_r1_enb),
  .ra0_w0_enb  (ra0_w0_enb),
  .cfg0        (cfg0)
);

`default_nettype wire

//--- test/toysram_control_tb.sv
// ======================================================================
// testbench for the SRAM command controller with a 32-row array model;
// run from build.f with toysram_control_tb as top
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "control_settings.svh"

module toysram_control_tb;

  import toysram_adr_pkg::*;

  localparam int          timeout_cycles = 4000;
  localparam logic [31:0] bist_region = `CTL_BIST_REGION;
  localparam logic [31:0] cfg_region = `CTL_CFG_REGION;
  // fixed word the array returns as bist status
  localparam logic [31:0] bist_status = 32'h5afe_c0de;

  logic                   clk;
  logic                   rst;
  logic                   ctl_cmd_val;
  logic                   ra0_cmd_val;
  logic                   cmd_we;
  cmd_adr_u               cmd_adr;
  logic [3:0]             cmd_sel;
  logic [31:0]            cmd_dat;
  logic                   rd_ack;
  logic [31:0]            rd_dat;
  logic                   ra0_clk;
  logic                   ra0_rst;
  logic                   ra0_cfg_wr;
  logic [31:0]            ra0_cfg_wdat;
  logic [31:0]            ra0_bist_ctl;
  logic [31:0]            ra0_w0_dat;
  logic                   ra0_r0_enb;
  logic                   ra0_r1_enb;
  logic                   ra0_w0_enb;
  logic [`CTL_ROW_W-1:0]  ra0_r0_adr;
  logic [`CTL_ROW_W-1:0]  ra0_r1_adr;
  logic [`CTL_ROW_W-1:0]  ra0_w0_adr;
  // array model state
  logic [31:0]            array_mem [0:31];
  logic [31:0]            r0_dat;
  logic [31:0]            r1_dat;
  logic [31:0]            cfg_rdat;
  // expected values from the array shadow and the cfg0 wait count
  logic [31:0]            shadow [0:31];
  logic [31:0]            acfg_exp;
  logic [2:0]             cur_wait;
  logic                   exp_w0;
  logic                   exp_r0_enb;
  logic                   exp_r1_enb;
  logic                   exp_cfg_wr;
  logic [31:0]            exp_bist_ctl;
  logic [31:0]            rand_state;
  int                     cycle_cnt = 0;

  toysram_control toysram_control_i (
    .clk             (clk),
    .rst             (rst),
    .ctl_cmd_val     (ctl_cmd_val),
    .ra0_cmd_val     (ra0_cmd_val),
    .cmd_adr         (cmd_adr),
    .cmd_we          (cmd_we),
    .cmd_sel         (cmd_sel),
    .cmd_dat         (cmd_dat),
    .rd_ack          (rd_ack),
    .rd_dat          (rd_dat),
    .ra0_clk         (ra0_clk),
    .ra0_rst         (ra0_rst),
    .ra0_cfg_wr      (ra0_cfg_wr),
    .ra0_cfg_rdat    (cfg_rdat),
    .ra0_cfg_wdat    (ra0_cfg_wdat),
    .ra0_bist_ctl    (ra0_bist_ctl),
    .ra0_bist_status (bist_status),
    .ra0_r0_enb      (ra0_r0_enb),
    .ra0_r0_adr      (ra0_r0_adr),
    .ra0_r0_dat      (r0_dat),
    .ra0_r1_enb      (ra0_r1_enb),
    .ra0_r1_adr      (ra0_r1_adr),
    .ra0_r1_dat      (r1_dat),
    .ra0_w0_enb      (ra0_w0_enb),
    .ra0_w0_adr      (ra0_w0_adr),
    .ra0_w0_dat      (ra0_w0_dat)
  );

  // whole-row fill pattern shared by model and shadow
  function automatic logic [31:0] fill_word(input int row);
    return 32'h9e37_79b9 * 32'(row + 1);
  endfunction

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic cmd_adr_u port_adr(input logic [1:0] kind, input logic [4:0] r1,
                                        input logic [4:0] r0);
    cmd_adr_u a;
    a.word         = '0;
    a.port.rd_type = kind;
    a.port.r1_row  = r1;
    a.port.r0_row  = r0;
    return a;
  endfunction

  // synchronous array with data valid from the edge after the enable
  always @(posedge ra0_clk) begin
    if (ra0_rst) begin
      r0_dat   <= '0;
      r1_dat   <= '0;
      cfg_rdat <= '0;
    end else begin
      if (ra0_w0_enb)
        array_mem[ra0_w0_adr] <= ra0_w0_dat;
      if (ra0_r0_enb)
        r0_dat <= array_mem[ra0_r0_adr];
      if (ra0_r1_enb)
        r1_dat <= array_mem[ra0_r1_adr];
      if (ra0_cfg_wr)
        cfg_rdat <= ra0_cfg_wdat;
    end
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic end_in_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic give_up(input string why);
    $display("%s", why);
    end_in_failure();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
    end_in_failure();
  endtask

  // watchdog plus the bound properties' error count
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
      give_up("timeout, the test did not finish within the cycle limit");
    else if (toysram_control_i.toysram_control_properties_i.fail_cnt != 0)
      give_up("a bound read timing property failed");
  end

  // per-cycle strobe checks against what the issued command implies
  w0_enb_ok: assert property (@(posedge clk) disable iff (rst) ra0_w0_enb == exp_w0)
    else report_mismatch("ra0_w0_enb", 32'(exp_w0), 32'(ra0_w0_enb));
  r0_enb_ok: assert property (@(posedge clk) disable iff (rst) ra0_r0_enb == exp_r0_enb)
    else report_mismatch("ra0_r0_enb", 32'(exp_r0_enb), 32'(ra0_r0_enb));
  r1_enb_ok: assert property (@(posedge clk) disable iff (rst) ra0_r1_enb == exp_r1_enb)
    else report_mismatch("ra0_r1_enb", 32'(exp_r1_enb), 32'(ra0_r1_enb));
  bist_ctl_ok: assert property (@(posedge clk) disable iff (rst) ra0_bist_ctl == exp_bist_ctl)
    else report_mismatch("ra0_bist_ctl", exp_bist_ctl, ra0_bist_ctl);
  cfg_wr_ok: assert property (@(posedge clk) disable iff (rst) ra0_cfg_wr == exp_cfg_wr)
    else report_mismatch("ra0_cfg_wr", 32'(exp_cfg_wr), 32'(ra0_cfg_wr));

  task automatic go_idle();
    ctl_cmd_val  = 1'b0;
    ra0_cmd_val  = 1'b0;
    exp_w0       = 1'b0;
    exp_r0_enb   = 1'b0;
    exp_r1_enb   = 1'b0;
    exp_cfg_wr   = 1'b0;
    exp_bist_ctl = '0;
  endtask

  // one command cycle entered and left 2 ns after a rising edge
  task automatic issue_cmd(input logic to_array, input logic we, input logic [31:0] adr,
                           input logic [3:0] sel, input logic [31:0] dat);
    logic special;
    logic plain_rd;
    special      = adr[15:12] == bist_region[15:12] || adr[15:12] == cfg_region[15:12];
    plain_rd     = to_array && !we && !special;
    ctl_cmd_val  = ~to_array;
    ra0_cmd_val  = to_array;
    cmd_we       = we;
    cmd_adr      = adr;
    cmd_sel      = sel;
    cmd_dat      = dat;
    exp_w0       = to_array && we && sel[0];
    // r0 serves types 00, 10 and 11, r1 serves types 01, 10 and 11
    exp_r0_enb   = plain_rd && (adr[15] || adr[15:14] == 2'b00);
    exp_r1_enb   = plain_rd && (adr[15] || adr[14]);
    exp_cfg_wr   = to_array && we && adr[15:12] == cfg_region[15:12];
    exp_bist_ctl = (to_array && we && adr[15:12] == bist_region[15:12]) ? dat : '0;
    @(posedge clk);
    #2;
    go_idle();
  endtask

  task automatic wait_for_ack(input int start, output int lat);
    lat = start;
    while (!rd_ack && lat < 16) begin
      @(posedge clk);
      #2;
      lat++;
    end
    assert (rd_ack) else give_up("no rd_ack within 16 cycles of a read command");
  endtask

  task automatic read_check(input logic to_array, input logic [31:0] adr,
                            input logic [31:0] exp, input string name);
    int lat;
    issue_cmd(to_array, 1'b0, adr, 4'hf, next_rand());
    wait_for_ack(1, lat);
    assert (lat == cur_wait + 1) else report_mismatch("rd_ack latency", cur_wait + 1, lat);
    assert (rd_dat == exp) else report_mismatch(name, exp, rd_dat);
    // sequencer idles again one cycle after the ack
    @(posedge clk);
    #2;
  endtask

  task automatic write_cfg0(input logic [31:0] word);
    issue_cmd(1'b0, 1'b1, 32'h0, 4'hf, word);
    cur_wait = word[2:0];
  endtask

  initial begin
    logic [31:0] dat;
    logic [4:0]  row;
    logic [4:0]  row_b;
    logic [4:0]  row_keep;
    int          lat;
    rand_state = 32'he6d1_9429;
    rst        = 1'b1;
    go_idle();
    cmd_we     = 1'b0;
    cmd_adr    = '0;
    cmd_sel    = '0;
    cmd_dat    = '0;
    cur_wait   = 3'd1;
    acfg_exp   = '0;
    for (int i = 0; i < 32; i++) begin
      array_mem[i] = fill_word(i);
      shadow[i]    = fill_word(i);
    end
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    // quiet after reset and then cfg0 reads back its reset value
    repeat (3) begin
      @(posedge clk);
      #2;
      assert (!rd_ack) else report_mismatch("rd_ack", 32'd0, 32'(rd_ack));
    end
    read_check(1'b0, 32'h0, 32'h1, "rd_dat cfg0 reset");

    // wait counts with both ends of the range first
    row = 5'(next_rand());
    for (int i = 0; i < 6; i++) begin
      dat = next_rand();
      if (i == 0)
        dat[2:0] = 3'd0;
      if (i == 1)
        dat[2:0] = 3'd7;
      write_cfg0(dat);
      read_check(1'b0, 32'h0, dat, "rd_dat cfg0");
      read_check(1'b1, port_adr(2'b00, 5'd0, row), shadow[row], "rd_dat r0");
    end
    write_cfg0({next_rand() & ~32'h7} | 32'h2);

    // single-port writes then reads where single r1 reads use r0_row
    repeat (16) begin
      row = 5'(next_rand());
      dat = next_rand();
      issue_cmd(1'b1, 1'b1, port_adr(2'b00, 5'd0, row), 4'b0001 | 4'(next_rand()), dat);
      shadow[row] = dat;
    end
    row_keep = 5'(next_rand());
    issue_cmd(1'b1, 1'b1, port_adr(2'b00, 5'd0, row_keep), 4'(next_rand()) & 4'b1110,
              next_rand());
    read_check(1'b1, port_adr(2'b00, 5'd0, row_keep), shadow[row_keep], "rd_dat sel0 clear");
    repeat (12) begin
      row = 5'(next_rand());
      read_check(1'b1, port_adr(2'b00, 5'd0, row), shadow[row], "rd_dat r0");
      read_check(1'b1, port_adr(2'b01, ~row, row), shadow[row], "rd_dat r1");
    end

    // dual reads put the r1 half above the r0 half
    repeat (8) begin
      row   = 5'(next_rand());
      row_b = row ^ (5'(next_rand()) | 5'd1);
      read_check(1'b1, port_adr(2'b10, row_b, row),
                 {shadow[row_b][15:0], shadow[row][15:0]}, "rd_dat dual low");
      read_check(1'b1, port_adr(2'b11, row_b, row),
                 {shadow[row_b][31:16], shadow[row][31:16]}, "rd_dat dual high");
    end

    // bist and array config pass through
    issue_cmd(1'b1, 1'b1, bist_region, 4'b0000, next_rand());
    acfg_exp = next_rand();
    issue_cmd(1'b1, 1'b1, cfg_region, 4'b0000, acfg_exp);
    read_check(1'b0, bist_region, bist_status, "rd_dat bist status");
    read_check(1'b0, cfg_region, acfg_exp, "rd_dat array config");

    // a second read while busy gets dropped
    dat = {next_rand() & ~32'h7} | 32'h5;
    write_cfg0(dat);
    issue_cmd(1'b0, 1'b0, 32'h0, 4'hf, next_rand());
    @(posedge clk);
    #2;
    issue_cmd(1'b0, 1'b0, bist_region, 4'hf, next_rand());
    wait_for_ack(3, lat);
    assert (lat == 6) else report_mismatch("rd_ack latency busy", 32'd6, lat);
    assert (rd_dat == dat) else report_mismatch("rd_dat busy", dat, rd_dat);
    repeat (10) begin
      @(posedge clk);
      #2;
      assert (!rd_ack) else report_mismatch("rd_ack dropped read", 32'd0, 32'(rd_ack));
    end

    if (toysram_control_i.toysram_control_properties_i.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      give_up("a bound read timing property failed");
    end
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
logic/toysram_adr_pkg.sv
logic/toysram_data_pkg.sv
logic/cmd_decode.sv
logic/read_sequencer.sv
logic/read_return.sv
logic/toysram_control.sv
test/toysram_control_properties.sv
test/toysram_control_tb.sv

//--- Bender.yml
package:
  name: toysram_control

export_include_dirs:
  - include

sources:
  - files:
      - logic/toysram_adr_pkg.sv
      - logic/toysram_data_pkg.sv
      - logic/cmd_decode.sv
      - logic/read_sequencer.sv
      - logic/read_return.sv
      - logic/toysram_control.sv
  - target: test
    files:
      - test/toysram_control_properties.sv
      - test/toysram_control_tb.sv
